//--- filelist.f
fix_pkg.sv
fix_tag_parser.sv
fix_checksum.sv
fix_seq_tracker.sv
fix_msg_processor.sv
fix_rx_top.sv
tb_fix_rx.sv

//--- fix_checksum.sv
// fix checksum unit, modulo-256 byte sum checked against the tag 10 value
`timescale 1ns/1ps

module fix_checksum (
	input  logic                clk,
	input  logic                rst,
	input  logic                byte_fire_i,
	input  logic [7:0]          byte_i,
	input  logic                fld_valid_i,
	input  fix_pkg::fix_field_t fld_i,
	output logic                csum_ok_o
);

	logic [7:0] sum;
	logic [7:0] sum_saved;	// sum up to the soh before "10="

	always_ff @(posedge clk) begin
		if (rst) begin
			sum       <= 8'd0;
			sum_saved <= 8'd0;
		end else begin
			if (fld_valid_i && fld_i.last) begin
				// first byte of the next message may already be here
				sum <= byte_fire_i ? byte_i : 8'd0;
			end else if (byte_fire_i) begin
				sum <= sum + byte_i;	// wraps mod 256
			end

			if (fld_valid_i && !fld_i.last)
				sum_saved <= sum;
		end
	end

	// only meaningful with the last field's fld_valid
	assign csum_ok_o = (fld_i.num == fix_pkg::NUM_W'(sum_saved));

endmodule

//--- fix_msg_processor.sv
// fix message processor, header-order FSM, body field capture and per-message verdict
`timescale 1ns/1ps

module fix_msg_processor (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fld_valid_i,
	input  fix_pkg::fix_field_t       fld_i,
	input  logic                      csum_ok_i,
	input  logic [fix_pkg::SEQ_W-1:0] expected_seq_i,
	output logic                      busy_o,
	output logic                      rpt_valid_o,
	output fix_pkg::fix_report_t      rpt_o,
	input  logic                      rpt_ready_i
);

	fix_pkg::proc_state_e      state;
	fix_pkg::proc_state_e      state_n;
	fix_pkg::fix_kind_e        kind_q;
	fix_pkg::fix_kind_e        kind_dec;
	fix_pkg::fix_kind_e        kind_fin;
	fix_pkg::fix_err_e         err_n;
	logic                      issue;
	logic [fix_pkg::SEQ_W-1:0] seq_q;
	logic [fix_pkg::SEQ_W-1:0] new_seq_q;
	logic [fix_pkg::NUM_W-1:0] len_exp_q;	// value of tag 9
	logic [15:0]               body_len_q;
	logic                      f_sender;
	logic                      f_target;
	logic                      f_time;
	logic                      poss_dup;
	logic                      gap_fill;
	logic                      seq_low;
	logic                      bad_frame;
	logic                      tag_missing;
	logic                      seq_high;

	function automatic fix_pkg::fix_kind_e msg_kind(input logic [fix_pkg::VALUE_W-1:0] raw);
		if (raw[fix_pkg::VALUE_W-1:8] != '0)
			return fix_pkg::KIND_NONE;	// multi-char types unsupported
		case (raw[7:0])
			fix_pkg::MT_HEARTBEAT:  return fix_pkg::KIND_HEARTBEAT;
			fix_pkg::MT_TEST_REQ:   return fix_pkg::KIND_TEST_REQ;
			fix_pkg::MT_RESEND_REQ: return fix_pkg::KIND_RESEND_REQ;
			fix_pkg::MT_REJECT:     return fix_pkg::KIND_REJECT;
			fix_pkg::MT_SEQ_RESET:  return fix_pkg::KIND_SEQ_RESET;
			fix_pkg::MT_LOGOUT:     return fix_pkg::KIND_LOGOUT;
			fix_pkg::MT_LOGON:      return fix_pkg::KIND_LOGON;
			default:                return fix_pkg::KIND_NONE;
		endcase
	endfunction

	assign busy_o = rpt_valid_o && !rpt_ready_i;

	always_comb begin
		kind_dec = msg_kind(fld_i.raw);
		kind_fin = (kind_q == fix_pkg::KIND_SEQ_RESET && gap_fill) ? fix_pkg::KIND_GAP_FILL : kind_q;
		// a pure seq reset may go backwards, a gap fill may not
		seq_low     = (seq_q < expected_seq_i) && !poss_dup && (kind_fin != fix_pkg::KIND_SEQ_RESET);
		bad_frame   = !csum_ok_i || (fix_pkg::NUM_W'(body_len_q) != len_exp_q);
		tag_missing = !(f_sender && f_target && f_time);
		seq_high    = seq_q > expected_seq_i;

		state_n = state;
		issue   = 1'b0;
		err_n   = fix_pkg::ERR_NONE;
		if (state == fix_pkg::S_REPORT) begin
			if (rpt_valid_o && rpt_ready_i)
				state_n = fix_pkg::S_BEGIN;
		end else if (fld_valid_i) begin
			case (state)
				fix_pkg::S_BEGIN: begin
					if (fld_i.tag != fix_pkg::TAG_BEGIN_STRING) begin
						issue = 1'b1;
						err_n = fix_pkg::ERR_GARBLED;
					end else if (fld_i.raw > {8'h00, fix_pkg::SUPPORTED_VERSION}) begin
						issue = 1'b1;
						err_n = fix_pkg::ERR_VERSION;
					end else begin
						state_n = fix_pkg::S_LENGTH;
					end
				end
				fix_pkg::S_LENGTH: begin
					if (fld_i.tag != fix_pkg::TAG_BODY_LENGTH) begin
						issue = 1'b1;
						err_n = fix_pkg::ERR_GARBLED;
					end else begin
						state_n = fix_pkg::S_TYPE;
					end
				end
				fix_pkg::S_TYPE: begin
					if (fld_i.tag != fix_pkg::TAG_MSG_TYPE) begin
						issue = 1'b1;
						err_n = fix_pkg::ERR_GARBLED;
					end else if (kind_dec == fix_pkg::KIND_NONE) begin
						issue = 1'b1;
						err_n = fix_pkg::ERR_MSG_TYPE;
					end else begin
						state_n = fix_pkg::S_SEQ;
					end
				end
				fix_pkg::S_SEQ: begin
					if (fld_i.tag != fix_pkg::TAG_MSG_SEQ_NUM) begin
						issue = 1'b1;
						err_n = fix_pkg::ERR_GARBLED;
					end else begin
						state_n = fix_pkg::S_BODY;
					end
				end
				fix_pkg::S_BODY: begin
					if (fld_i.last) begin
						issue = 1'b1;
						if (seq_low)          err_n = fix_pkg::ERR_SEQ_LOW;
						else if (bad_frame)   err_n = fix_pkg::ERR_GARBLED;
						else if (tag_missing) err_n = fix_pkg::ERR_TAG_MISSING;
						else if (seq_high)    err_n = fix_pkg::ERR_SEQ_HIGH;
					end
				end
				fix_pkg::S_DISCARD: if (fld_i.last) state_n = fix_pkg::S_BEGIN;
				default: state_n = fix_pkg::S_BEGIN;
			endcase
		end
		if (issue)
			state_n = fld_i.last ? fix_pkg::S_REPORT : fix_pkg::S_DISCARD;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= fix_pkg::S_BEGIN;
			rpt_valid_o <= 1'b0;
			kind_q      <= fix_pkg::KIND_NONE;
			seq_q       <= '0;
			new_seq_q   <= '0;
			len_exp_q   <= '0;
			body_len_q  <= '0;
			{f_sender, f_target, f_time, poss_dup, gap_fill} <= '0;
		end else begin
			state <= state_n;
			if (issue)
				rpt_valid_o <= 1'b1;
			else if (rpt_ready_i)
				rpt_valid_o <= 1'b0;

			if (fld_valid_i && fld_i.last) begin
				// message done, clear for the next one
				kind_q     <= fix_pkg::KIND_NONE;
				seq_q      <= '0;
				new_seq_q  <= '0;
				body_len_q <= '0;
				{f_sender, f_target, f_time, poss_dup, gap_fill} <= '0;
			end else if (fld_valid_i) begin
				case (state)
					fix_pkg::S_LENGTH: len_exp_q <= fld_i.num;
					fix_pkg::S_TYPE: begin
						kind_q     <= kind_dec;
						body_len_q <= body_len_q + fld_i.len;
					end
					fix_pkg::S_SEQ: begin
						seq_q      <= fix_pkg::SEQ_W'(fld_i.num);
						body_len_q <= body_len_q + fld_i.len;
					end
					fix_pkg::S_BODY: begin
						body_len_q <= body_len_q + fld_i.len;
						case (fld_i.tag)
							fix_pkg::TAG_SENDER_COMP_ID: f_sender <= 1'b1;
							fix_pkg::TAG_TARGET_COMP_ID: f_target <= 1'b1;
							fix_pkg::TAG_SENDING_TIME:   f_time   <= 1'b1;
							fix_pkg::TAG_POSS_DUP:   poss_dup  <= (fld_i.raw[7:0] == fix_pkg::CH_Y);
							fix_pkg::TAG_GAP_FILL:   gap_fill  <= (fld_i.raw[7:0] == fix_pkg::CH_Y);
							fix_pkg::TAG_NEW_SEQ_NO: new_seq_q <= fix_pkg::SEQ_W'(fld_i.num);
							default: ;	// other tags ignored
						endcase
					end
					default: ;
				endcase
			end
		end
	end

	// report payload, loaded only when a verdict is issued
	always_ff @(posedge clk) begin
		if (issue) begin
			rpt_o.kind       <= kind_fin;
			rpt_o.err        <= err_n;
			rpt_o.seq_num    <= seq_q;
			rpt_o.new_seq_no <= new_seq_q;
		end
	end

	a_rpt_hold: assert property (@(posedge clk) disable iff (rst)
		(rpt_valid_o && !rpt_ready_i) |=> (rpt_valid_o && $stable(rpt_o)));

endmodule

//--- fix_pkg.sv
// fix rx package with tag numbers, widths, enums and structs for the receive path
package fix_pkg;

	localparam int VALUE_W = 64;	// last 8 value bytes, right-aligned
	localparam int NUM_W   = 32;
	localparam int SEQ_W   = 32;

	// tag numbers used by the processor
	localparam logic [15:0] TAG_BEGIN_STRING   = 16'd8;
	localparam logic [15:0] TAG_BODY_LENGTH    = 16'd9;
	localparam logic [15:0] TAG_MSG_TYPE       = 16'd35;
	localparam logic [15:0] TAG_MSG_SEQ_NUM    = 16'd34;
	localparam logic [15:0] TAG_SENDER_COMP_ID = 16'd49;
	localparam logic [15:0] TAG_TARGET_COMP_ID = 16'd56;
	localparam logic [15:0] TAG_SENDING_TIME   = 16'd52;
	localparam logic [15:0] TAG_POSS_DUP       = 16'd43;
	localparam logic [15:0] TAG_GAP_FILL       = 16'd123;
	localparam logic [15:0] TAG_NEW_SEQ_NO     = 16'd36;
	localparam logic [15:0] TAG_CHECKSUM       = 16'd10;

	// ascii
	localparam logic [7:0] CH_SOH  = 8'h01;
	localparam logic [7:0] CH_EQ   = 8'h3D;	// '='
	localparam logic [7:0] CH_ZERO = 8'h30;
	localparam logic [7:0] CH_NINE = 8'h39;
	localparam logic [7:0] CH_Y    = 8'h59;

	// msgtype values, single character
	localparam logic [7:0] MT_HEARTBEAT  = 8'h30;	// '0'
	localparam logic [7:0] MT_TEST_REQ   = 8'h31;
	localparam logic [7:0] MT_RESEND_REQ = 8'h32;
	localparam logic [7:0] MT_REJECT     = 8'h33;
	localparam logic [7:0] MT_SEQ_RESET  = 8'h34;
	localparam logic [7:0] MT_LOGOUT     = 8'h35;
	localparam logic [7:0] MT_LOGON      = 8'h41;	// 'A'

	localparam logic [55:0] SUPPORTED_VERSION = 56'h46_49_58_2E_34_2E_33;	// FIX.4.3

	typedef enum logic [2:0] {
		ERR_NONE,
		ERR_GARBLED,
		ERR_VERSION,
		ERR_MSG_TYPE,
		ERR_TAG_MISSING,
		ERR_SEQ_LOW,
		ERR_SEQ_HIGH
	} fix_err_e;

	typedef enum logic [3:0] {
		KIND_HEARTBEAT,
		KIND_TEST_REQ,
		KIND_RESEND_REQ,
		KIND_REJECT,
		KIND_SEQ_RESET,
		KIND_GAP_FILL,	// seq reset with 123=Y
		KIND_LOGOUT,
		KIND_LOGON,
		KIND_NONE
	} fix_kind_e;

	typedef enum logic {P_TAG, P_VALUE} parse_state_e;

	typedef enum logic [2:0] {
		S_BEGIN, S_LENGTH, S_TYPE, S_SEQ, S_BODY, S_DISCARD, S_REPORT
	} proc_state_e;

	typedef struct packed {
		logic [15:0]        tag;
		logic [VALUE_W-1:0] raw;
		logic [NUM_W-1:0]   num;	// zero on any non-digit
		logic [15:0]        len;	// whole field incl. soh
		logic               first;
		logic               last;	// tag 10
	} fix_field_t;

	typedef struct packed {
		fix_kind_e        kind;
		fix_err_e         err;
		logic [SEQ_W-1:0] seq_num;
		logic [SEQ_W-1:0] new_seq_no;
	} fix_report_t;

endpackage

//--- fix_rx_top.sv
// fix receive top, parser, checksum, message processor and sequence tracker
`timescale 1ns/1ps

module fix_rx_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 byte_valid_i,
	input  logic [7:0]           byte_i,
	output logic                 byte_ready_o,
	output logic                 rpt_valid_o,
	output fix_pkg::fix_report_t rpt_o,
	input  logic                 rpt_ready_i
);

	logic                      byte_fire;
	logic                      fld_valid;
	fix_pkg::fix_field_t       fld;
	logic                      csum_ok;
	logic                      proc_busy;
	logic [fix_pkg::SEQ_W-1:0] expected_seq;
	wire                       rpt_fire = rpt_valid_o && rpt_ready_i;

	fix_tag_parser u_parser (
		.clk          (clk),
		.rst          (rst),
		.byte_valid_i (byte_valid_i),
		.byte_i       (byte_i),
		.byte_ready_o (byte_ready_o),
		.busy_i       (proc_busy),
		.byte_fire_o  (byte_fire),
		.fld_valid_o  (fld_valid),
		.fld_o        (fld)
	);

	fix_checksum u_csum (
		.clk         (clk),
		.rst         (rst),
		.byte_fire_i (byte_fire),
		.byte_i      (byte_i),
		.fld_valid_i (fld_valid),
		.fld_i       (fld),
		.csum_ok_o   (csum_ok)
	);

	fix_msg_processor u_proc (
		.clk            (clk),
		.rst            (rst),
		.fld_valid_i    (fld_valid),
		.fld_i          (fld),
		.csum_ok_i      (csum_ok),
		.expected_seq_i (expected_seq),
		.busy_o         (proc_busy),
		.rpt_valid_o    (rpt_valid_o),
		.rpt_o          (rpt_o),
		.rpt_ready_i    (rpt_ready_i)
	);

	fix_seq_tracker u_seq (
		.clk            (clk),
		.rst            (rst),
		.rpt_fire_i     (rpt_fire),
		.rpt_i          (rpt_o),
		.expected_seq_o (expected_seq)
	);

endmodule

//--- fix_seq_tracker.sv
// fix sequence tracker, expected incoming MsgSeqNum updated from accepted reports
`timescale 1ns/1ps

module fix_seq_tracker (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rpt_fire_i,
	input  fix_pkg::fix_report_t      rpt_i,
	output logic [fix_pkg::SEQ_W-1:0] expected_seq_o
);

	logic plain_ok;	// good message that is not a reset

	assign plain_ok = rpt_fire_i && (rpt_i.err == fix_pkg::ERR_NONE) &&
		(rpt_i.kind != fix_pkg::KIND_SEQ_RESET) && (rpt_i.kind != fix_pkg::KIND_GAP_FILL);

	always_ff @(posedge clk) begin
		if (rst) begin
			expected_seq_o <= fix_pkg::SEQ_W'(1);
		end else if (rpt_fire_i && rpt_i.err == fix_pkg::ERR_NONE) begin
			case (rpt_i.kind)
				fix_pkg::KIND_SEQ_RESET: expected_seq_o <= rpt_i.new_seq_no;
				fix_pkg::KIND_GAP_FILL:  expected_seq_o <= rpt_i.new_seq_no;
				default:                 expected_seq_o <= expected_seq_o + 1'b1;
			endcase
		end
		// rejected messages leave it alone
	end

	a_seq_step: assert property (@(posedge clk) disable iff (rst)
		plain_ok |=> (expected_seq_o == $past(expected_seq_o) + 1'b1));

endmodule

//--- fix_tag_parser.sv
// fix tag parser, splits the byte stream into decoded tag/value fields
`timescale 1ns/1ps

module fix_tag_parser (
	input  logic                clk,
	input  logic                rst,
	input  logic                byte_valid_i,
	input  logic [7:0]          byte_i,
	output logic                byte_ready_o,
	input  logic                busy_i,
	output logic                byte_fire_o,
	output logic                fld_valid_o,
	output fix_pkg::fix_field_t fld_o
);

	fix_pkg::parse_state_e       state;
	logic [15:0]                 tag_acc;
	logic [fix_pkg::VALUE_W-1:0] raw_acc;
	logic [fix_pkg::NUM_W-1:0]   num_acc;
	logic                        non_digit;
	logic [15:0]                 len_cnt;
	logic                        first_pend;	// next field opens a message
	logic                        is_digit;
	logic [3:0]                  digit;
	logic                        is_soh;

	assign byte_ready_o = !busy_i;	// stall while a report waits
	assign byte_fire_o  = byte_valid_i && byte_ready_o;
	assign is_digit     = (byte_i >= fix_pkg::CH_ZERO) && (byte_i <= fix_pkg::CH_NINE);
	assign digit        = byte_i[3:0];
	assign is_soh       = (byte_i == fix_pkg::CH_SOH);

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= fix_pkg::P_TAG;
			tag_acc     <= '0;
			len_cnt     <= '0;
			first_pend  <= 1'b1;
			fld_valid_o <= 1'b0;
		end else begin
			fld_valid_o <= 1'b0;
			if (byte_fire_o) begin
				len_cnt <= len_cnt + 16'd1;
				case (state)
					fix_pkg::P_TAG: begin
						if (byte_i == fix_pkg::CH_EQ) begin
							state <= fix_pkg::P_VALUE;
						end else if (is_soh) begin
							// stray soh, no value
							tag_acc <= '0;
							len_cnt <= '0;
						end else begin
							tag_acc <= (tag_acc << 3) + (tag_acc << 1) + 16'(digit);
						end
					end
					fix_pkg::P_VALUE: begin
						if (is_soh) begin
							state       <= fix_pkg::P_TAG;
							fld_valid_o <= 1'b1;
							first_pend  <= (tag_acc == fix_pkg::TAG_CHECKSUM);
							tag_acc     <= '0;
							len_cnt     <= '0;
						end
					end
					default: state <= fix_pkg::P_TAG;
				endcase
			end
		end
	end

	// value shift-in and field capture
	always_ff @(posedge clk) begin
		if (byte_fire_o) begin
			if (state == fix_pkg::P_TAG) begin
				raw_acc   <= '0;
				num_acc   <= '0;
				non_digit <= 1'b0;
			end else if (is_soh) begin
				fld_o.tag   <= tag_acc;
				fld_o.raw   <= raw_acc;
				fld_o.num   <= non_digit ? '0 : num_acc;
				fld_o.len   <= len_cnt + 16'd1;
				fld_o.first <= first_pend;
				fld_o.last  <= (tag_acc == fix_pkg::TAG_CHECKSUM);
			end else begin
				raw_acc <= {raw_acc[fix_pkg::VALUE_W-9:0], byte_i};
				if (is_digit)
					num_acc <= (num_acc << 3) + (num_acc << 1) + fix_pkg::NUM_W'(digit);
				else
					non_digit <= 1'b1;
			end
		end
	end

	// each field takes at least two bytes
	a_fld_pulse: assert property (@(posedge clk) disable iff (rst)
		fld_valid_o |=> !fld_valid_o);

endmodule

//--- tb_fix_rx.sv
// fix rx testbench, directed message tests with random report back-pressure
`timescale 1ns/1ps

module tb_fix_rx;

	localparam int MAX_CYCLES = 4000;	// ~20 messages of ~70 bytes plus stalls, with margin

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 byte_valid_i;
	logic [7:0]           byte_i;
	logic                 byte_ready_o;
	logic                 rpt_valid_o;
	fix_pkg::fix_report_t rpt_o;
	logic                 rpt_ready_i;

	fix_pkg::fix_report_t exp_q[$];	// reports still awaited, in order
	string                name_q[$];
	int                   ref_seq = 1;	// model of the expected incoming seq
	int unsigned          lcg_state = 57;
	int                   cycles = 0;
	int                   checks = 0;
	int                   errors = 0;

	fix_rx_top uut (
		.clk          (clk),
		.rst          (rst),
		.byte_valid_i (byte_valid_i),
		.byte_i       (byte_i),
		.byte_ready_o (byte_ready_o),
		.rpt_valid_o  (rpt_valid_o),
		.rpt_o        (rpt_o),
		.rpt_ready_i  (rpt_ready_i)
	);

	always #2 clk = ~clk;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function automatic logic [7:0] soh_map(input byte c);
		return (c == "|") ? fix_pkg::CH_SOH : c;	// '|' stands for soh in message text
	endfunction

	function automatic string fields(input string mt, input int seq, input bit with_time,
			input string extra);
		string s;
		s = {"35=", mt, "|34=", $sformatf("%0d", seq), "|49=CLIENT|56=ENGINE|"};
		if (with_time)
			s = {s, "52=T0930|"};
		return {s, extra};
	endfunction

	task automatic check_kind(input string name, input fix_pkg::fix_kind_e exp,
			input fix_pkg::fix_kind_e act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s kind: expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_err(input string name, input fix_pkg::fix_err_e exp,
			input fix_pkg::fix_err_e act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s err: expected %s actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_seq(input string name, input logic [fix_pkg::SEQ_W-1:0] exp,
			input logic [fix_pkg::SEQ_W-1:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("mismatch %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_report(input string name, input fix_pkg::fix_report_t exp,
			input fix_pkg::fix_report_t act);
		check_kind(name, exp.kind, act.kind);
		check_err(name, exp.err, act.err);
		check_seq({name, " seq_num"}, exp.seq_num, act.seq_num);
		check_seq({name, " new_seq_no"}, exp.new_seq_no, act.new_seq_no);
	endtask

	// queue the verdict and step the reference seq by the tracker rule
	task automatic expect_report(input string name, input fix_pkg::fix_kind_e kind,
			input fix_pkg::fix_err_e err, input int seq, input int new_seq);
		fix_pkg::fix_report_t r;
		r.kind       = kind;
		r.err        = err;
		r.seq_num    = seq;
		r.new_seq_no = new_seq;
		exp_q.push_back(r);
		name_q.push_back(name);
		if (err == fix_pkg::ERR_NONE) begin
			if (kind == fix_pkg::KIND_SEQ_RESET || kind == fix_pkg::KIND_GAP_FILL)
				ref_seq = new_seq;
			else
				ref_seq++;
		end
	endtask

	// starts and ends on a falling edge
	task automatic send_byte(input logic [7:0] b);
		bit done;
		byte_valid_i = 1'b1;
		byte_i       = b;
		done         = 1'b0;
		while (!done) begin
			#1;
			done = byte_ready_o;	// settled ahead of the rising edge
			@(negedge clk);
		end
		byte_valid_i = 1'b0;
	endtask

	task automatic send_msg(input string ver, input bit hdr, input string body,
			input int len_adj, input int csum_adj);
		string text;
		int    sum;
		text = "";
		if (hdr)
			text = {"8=", ver, "|9=", $sformatf("%0d", body.len() + len_adj), "|"};
		text = {text, body};
		sum  = 0;
		for (int i = 0; i < text.len(); i++)
			sum += soh_map(text[i]);	// every byte up to the soh before 10=
		text = {text, "10=", $sformatf("%03d", (sum + csum_adj) % 256), "|"};
		for (int i = 0; i < text.len(); i++)
			send_byte(soh_map(text[i]));
	endtask

	task automatic plain_msg(input string name, input string mt, input int seq,
			input string extra, input fix_pkg::fix_kind_e kind, input fix_pkg::fix_err_e err,
			input int new_seq);
		expect_report(name, kind, err, seq, new_seq);
		send_msg("FIX.4.3", 1'b1, fields(mt, seq, 1'b1, extra), 0, 0);
	endtask

	task automatic drain_and_check(input string name);
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(negedge clk);	// tracker settles after the last transfer
		check_seq({name, " expected_seq"}, ref_seq, uut.expected_seq);
	endtask

	task automatic test_good_session();
		plain_msg("logon", "A", 1, "98=0|108=30|", fix_pkg::KIND_LOGON, fix_pkg::ERR_NONE, 0);
		plain_msg("heartbeat", "0", 2, "", fix_pkg::KIND_HEARTBEAT, fix_pkg::ERR_NONE, 0);
		plain_msg("test_req", "1", 3, "112=TR1|", fix_pkg::KIND_TEST_REQ, fix_pkg::ERR_NONE, 0);
		drain_and_check("good_session");
	endtask

	task automatic test_header_faults();
		// early verdicts carry no kind or seq yet
		expect_report("no_begin", fix_pkg::KIND_NONE, fix_pkg::ERR_GARBLED, 0, 0);
		send_msg("FIX.4.3", 1'b0, fields("0", ref_seq, 1'b1, ""), 0, 0);
		expect_report("version", fix_pkg::KIND_NONE, fix_pkg::ERR_VERSION, 0, 0);
		send_msg("FIX.4.4", 1'b1, fields("0", ref_seq, 1'b1, ""), 0, 0);
		expect_report("msg_type", fix_pkg::KIND_NONE, fix_pkg::ERR_MSG_TYPE, 0, 0);
		send_msg("FIX.4.3", 1'b1, fields("Z", ref_seq, 1'b1, ""), 0, 0);
		drain_and_check("header_faults");
		plain_msg("after_faults", "0", ref_seq, "", fix_pkg::KIND_HEARTBEAT,
			fix_pkg::ERR_NONE, 0);
		drain_and_check("after_faults");
	endtask

	task automatic test_frame_faults();
		expect_report("bad_csum", fix_pkg::KIND_HEARTBEAT, fix_pkg::ERR_GARBLED, ref_seq, 0);
		send_msg("FIX.4.3", 1'b1, fields("0", ref_seq, 1'b1, ""), 0, 1);
		expect_report("bad_length", fix_pkg::KIND_HEARTBEAT, fix_pkg::ERR_GARBLED, ref_seq, 0);
		send_msg("FIX.4.3", 1'b1, fields("0", ref_seq, 1'b1, ""), 1, 0);
		expect_report("no_time", fix_pkg::KIND_HEARTBEAT, fix_pkg::ERR_TAG_MISSING, ref_seq, 0);
		send_msg("FIX.4.3", 1'b1, fields("0", ref_seq, 1'b0, ""), 0, 0);
		drain_and_check("frame_faults");
	endtask

	task automatic test_seq_rules();
		plain_msg("seq_low", "0", 2, "", fix_pkg::KIND_HEARTBEAT, fix_pkg::ERR_SEQ_LOW, 0);
		plain_msg("poss_dup", "0", 3, "43=Y|", fix_pkg::KIND_HEARTBEAT, fix_pkg::ERR_NONE, 0);
		plain_msg("seq_high", "0", ref_seq + 3, "", fix_pkg::KIND_HEARTBEAT,
			fix_pkg::ERR_SEQ_HIGH, 0);
		drain_and_check("seq_low_high");
		plain_msg("seq_reset", "4", ref_seq, "36=20|", fix_pkg::KIND_SEQ_RESET,
			fix_pkg::ERR_NONE, 20);
		plain_msg("after_reset", "0", 20, "", fix_pkg::KIND_HEARTBEAT, fix_pkg::ERR_NONE, 0);
		plain_msg("gap_fill", "4", 21, "123=Y|36=25|", fix_pkg::KIND_GAP_FILL,
			fix_pkg::ERR_NONE, 25);
		drain_and_check("seq_reset_gap_fill");
	endtask

	// no draining between messages, reports pile up behind the stalls
	task automatic test_back_to_back();
		for (int k = 0; k < 6; k++) begin
			if (k == 3)
				plain_msg("b2b_high", "0", ref_seq + 5, "", fix_pkg::KIND_HEARTBEAT,
					fix_pkg::ERR_SEQ_HIGH, 0);
			else if (k % 2 == 1)
				plain_msg("b2b_test_req", "1", ref_seq, "112=B2B|", fix_pkg::KIND_TEST_REQ,
					fix_pkg::ERR_NONE, 0);
			else
				plain_msg("b2b_heartbeat", "0", ref_seq, "", fix_pkg::KIND_HEARTBEAT,
					fix_pkg::ERR_NONE, 0);
		end
		drain_and_check("back_to_back");
	endtask

	// report ready with random stalls, transfers recorded where they are decided
	always @(negedge clk) begin
		rpt_ready_i = (lcg_next() % 3) != 0;
		if (rpt_valid_o && rpt_ready_i) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("unexpected report with no message pending");
			end else begin
				check_report(name_q.pop_front(), exp_q.pop_front(), rpt_o);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("checks: %0d errors: %0d", checks, errors + 1);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial begin
		rst          = 1'b1;
		byte_valid_i = 1'b0;
		byte_i       = 8'h00;
		rpt_ready_i  = 1'b0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		if (rpt_valid_o || !byte_ready_o) begin
			errors++;
			$display("report port or byte port not idle after reset");
		end
		check_seq("reset expected_seq", 1, uut.expected_seq);
		test_good_session();
		test_header_faults();
		test_frame_faults();
		test_seq_rules();
		test_back_to_back();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
